//--- logic/exc_config.svh
`ifndef EXC_CONFIG_SVH
`define EXC_CONFIG_SVH

// fixed exception entry, no BEV or vectored modes
`define EXC_ENTRY 32'hBFC0_0380

// external interrupt lines, mapped onto Cause.IP[15:10]
`define INT_LINES 6

// flops in the ext_int synchronizer
`define SYNC_STAGES 2

// APB byte offsets of the CP0 registers
`define CP0_STATUS_OFS   4'h0
`define CP0_CAUSE_OFS    4'h4
`define CP0_EPC_OFS      4'h8
`define CP0_BADVADDR_OFS 4'hC

`endif

//--- logic/exc_pkg.sv
package exc_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        CPU  = 5'd11,
        OV   = 5'd12,
        TR   = 5'd13
    } exc_code_t;

    // fault flags carried by the committing instruction
    typedef struct packed {
        logic instr_adel;
        logic instr_tlb;
        logic cpu;
        logic ri;
        logic ov;
        logic bp;
        logic sys;
        logic tr;
        logic load_adel;
        logic store_ades;
        logic load_tlb;
        logic store_tlb;
        logic mod;
    } exc_flags_t;

    // Status fields, reserved bits read as zero
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;
        logic [4:0]  rsvd_lo;
        logic        erl;
        logic        exl;
        logic        ie;
    } cp0_status_f_t;

    // Status seen as a host word or as named fields
    typedef union packed {
        word_t         raw;
        cp0_status_f_t fld;
    } cp0_status_u;

    // ip[7:2] hardware lines, ip[1:0] software
    typedef struct packed {
        logic        bd;
        logic [14:0] rsvd_hi;
        logic [7:0]  ip;
        logic        rsvd_mid;
        exc_code_t   exc_code;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

endpackage

//--- logic/exc_priority.sv
`include "exc_config.svh"
`timescale 1ns/10ps

module exc_priority (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_valid,
    input  exc_pkg::exc_flags_t   commit_flags,
    input  logic                  commit_eret,
    input  exc_pkg::word_t        epc,
    input  exc_pkg::cp0_status_u  status,
    input  logic [7:0]            int_pending,
    output logic                  exception_valid,
    output exc_pkg::exc_code_t    exception_code,
    output logic                  take_exc,
    output logic                  take_eret,
    output exc_pkg::exc_code_t    take_code,
    output logic                  redirect_valid,
    output exc_pkg::word_t        redirect_pc
);
    import exc_pkg::*;

    logic      int_accept;
    logic      fault_any;
    exc_code_t code;

    // interrupts are held off at exception or error level
    assign int_accept = (|int_pending) & status.fld.ie
                      & ~status.fld.exl & ~status.fld.erl;
    assign fault_any  = |commit_flags;

    // interrupt first, then fetch-side faults, then execute, then memory
    always_comb begin
        priority case (1'b1)
            int_accept:              code = INT;
            commit_flags.instr_adel: code = ADEL;
            commit_flags.instr_tlb:  code = TLBL;
            commit_flags.cpu:        code = CPU;
            commit_flags.ri:         code = RI;
            commit_flags.ov:         code = OV;
            commit_flags.bp:         code = BP;
            commit_flags.sys:        code = SYS;
            commit_flags.tr:         code = TR;
            commit_flags.load_adel:  code = ADEL;
            commit_flags.store_ades: code = ADES;
            commit_flags.load_tlb:   code = TLBL;
            commit_flags.store_tlb:  code = TLBS;
            commit_flags.mod:        code = MOD;
            default:                 code = INT;
        endcase
    end

    assign take_exc  = commit_valid & (int_accept | fault_any);
    // a faulting eret takes the fault
    assign take_eret = commit_valid & commit_eret & ~take_exc;
    assign take_code = code;

    assign exception_valid = take_exc;
    assign exception_code  = code;

    assign redirect_valid = take_exc | take_eret;
    assign redirect_pc    = take_exc ? `EXC_ENTRY : epc;

    a_exc_eret_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(take_exc && take_eret)
    );

    // an empty slot never redirects fetch
    a_idle_slot: assert property (
        @(posedge clk) disable iff (rst)
        !commit_valid |-> !redirect_valid && !exception_valid
    );

endmodule

//--- logic/cp0_regs.sv
`include "exc_config.svh"
`timescale 1ns/10ps

module cp0_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INT_LINES-1:0] ext_int,
    input  logic                  take_exc,
    input  logic                  take_eret,
    input  exc_pkg::exc_code_t    take_code,
    input  exc_pkg::word_t        commit_pc,
    input  exc_pkg::word_t        commit_vaddr,
    input  logic                  commit_in_delay_slot,
    input  logic                  wr_en,
    input  logic [1:0]            wr_sel,
    input  logic [1:0]            rd_sel,
    input  exc_pkg::word_t        wr_data,
    output exc_pkg::word_t        rd_data,
    output exc_pkg::cp0_status_u  status,
    output exc_pkg::word_t        epc,
    output logic [7:0]            int_pending
);
    import exc_pkg::*;

    localparam logic [1:0] SEL_STATUS   = 2'(`CP0_STATUS_OFS >> 2);
    localparam logic [1:0] SEL_CAUSE    = 2'(`CP0_CAUSE_OFS >> 2);
    localparam logic [1:0] SEL_EPC      = 2'(`CP0_EPC_OFS >> 2);
    localparam logic [1:0] SEL_BADVADDR = 2'(`CP0_BADVADDR_OFS >> 2);
    // IM, ERL, EXL, IE
    localparam word_t STATUS_WMASK = 32'h0000_ff07;

    logic [`INT_LINES-1:0] int_sync [`SYNC_STAGES];
    cp0_cause_t            cause;
    word_t                 badvaddr;
    logic                  addr_err;
    logic                  fetch_adel;

    // two-flop synchronizer, cause.ip picks it up one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                int_sync[i] <= '0;
            end
        end else begin
            int_sync[0] <= ext_int;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                int_sync[i] <= int_sync[i-1];
            end
        end
    end

    // no user mode here, so a fetch address error means a misaligned pc
    assign addr_err   = take_exc & ((take_code == ADEL) | (take_code == ADES));
    assign fetch_adel = (take_code == ADEL) & (commit_pc[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (rst) begin
            status.raw <= 32'h0000_0004;
        end else if (take_exc) begin
            status.fld.exl <= 1'b1;
        end else if (take_eret) begin
            status.fld.exl <= 1'b0;
        end else if (wr_en && wr_sel == SEL_STATUS) begin
            status.raw <= wr_data & STATUS_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause <= '0;
        end else begin
            cause.ip[7:2] <= int_sync[`SYNC_STAGES-1];
            if (take_exc) begin
                cause.exc_code <= take_code;
                // bd only tracks the first exception of a nest
                if (!status.fld.exl) begin
                    cause.bd <= commit_in_delay_slot;
                end
            end else if (wr_en && wr_sel == SEL_CAUSE) begin
                cause.ip[1:0] <= wr_data[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (take_exc) begin
            if (!status.fld.exl) begin
                epc <= commit_in_delay_slot ? commit_pc - 32'd4 : commit_pc;
            end
        end else if (wr_en && wr_sel == SEL_EPC) begin
            epc <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr <= '0;
        end else if (addr_err) begin
            badvaddr <= fetch_adel ? commit_pc : commit_vaddr;
        end
    end

    assign int_pending = cause.ip & status.fld.im;

    always_comb begin
        case (rd_sel)
            SEL_STATUS:   rd_data = status.raw;
            SEL_CAUSE:    rd_data = cause;
            SEL_EPC:      rd_data = epc;
            SEL_BADVADDR: rd_data = badvaddr;
            default:      rd_data = '0;
        endcase
    end

    a_badvaddr_ldst: assert property (
        @(posedge clk) disable iff (rst)
        addr_err && !fetch_adel |=> badvaddr == $past(commit_vaddr)
    );

endmodule

//--- logic/cp0_apb.sv
`include "exc_config.svh"
`timescale 1ns/10ps

module cp0_apb (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [3:0]      paddr,
    input  exc_pkg::word_t  pwdata,
    output exc_pkg::word_t  prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            wr_en,
    output logic [1:0]      wr_sel,
    output logic [1:0]      rd_sel,
    output exc_pkg::word_t  wr_data,
    input  exc_pkg::word_t  rd_data
);
    localparam logic [1:0] SEL_BADVADDR = 2'(`CP0_BADVADDR_OFS >> 2);

    logic [1:0] reg_sel;
    logic       setup;
    logic       access;
    logic       ro_hit;

    // low address bits ignored, four word registers
    assign reg_sel = paddr[3:2];
    assign setup   = psel & ~penable;
    assign access  = psel & penable;
    // badvaddr is read only
    assign ro_hit  = pwrite & (reg_sel == SEL_BADVADDR);

    assign rd_sel  = reg_sel;
    assign wr_sel  = reg_sel;
    assign wr_data = pwdata;
    // lands on the edge closing the access cycle
    assign wr_en   = access & pwrite & ~ro_hit;

    // response set up during the setup cycle, zero wait states
    always_ff @(posedge clk) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= setup;
            pslverr <= setup & ro_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && !pwrite) begin
            prdata <= rd_data;
        end
    end

    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        $rose(penable) |-> psel
    );

endmodule

//--- logic/exc_top.sv
`include "exc_config.svh"
`timescale 1ns/10ps

module exc_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_valid,
    input  exc_pkg::exc_flags_t   commit_flags,
    input  exc_pkg::word_t        commit_pc,
    input  exc_pkg::word_t        commit_vaddr,
    input  logic                  commit_in_delay_slot,
    input  logic                  commit_eret,
    input  logic [`INT_LINES-1:0] ext_int,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  exc_pkg::word_t        pwdata,
    output exc_pkg::word_t        prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  exception_valid,
    output exc_pkg::exc_code_t    exception_code,
    output logic                  redirect_valid,
    output exc_pkg::word_t        redirect_pc
);
    import exc_pkg::*;

    cp0_status_u status;
    logic [7:0]  int_pending;
    word_t       epc;
    logic        take_exc;
    logic        take_eret;
    exc_code_t   take_code;

    // host access path
    logic        wr_en;
    logic [1:0]  wr_sel;
    logic [1:0]  rd_sel;
    word_t       wr_data;
    word_t       rd_data;

    exc_priority u_priority (
        .clk             (clk),
        .rst             (rst),
        .commit_valid    (commit_valid),
        .commit_flags    (commit_flags),
        .commit_eret     (commit_eret),
        .epc             (epc),
        .status          (status),
        .int_pending     (int_pending),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .take_exc        (take_exc),
        .take_eret       (take_eret),
        .take_code       (take_code),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

    cp0_regs u_cp0 (
        .clk                  (clk),
        .rst                  (rst),
        .ext_int              (ext_int),
        .take_exc             (take_exc),
        .take_eret            (take_eret),
        .take_code            (take_code),
        .commit_pc            (commit_pc),
        .commit_vaddr         (commit_vaddr),
        .commit_in_delay_slot (commit_in_delay_slot),
        .wr_en                (wr_en),
        .wr_sel               (wr_sel),
        .rd_sel               (rd_sel),
        .wr_data              (wr_data),
        .rd_data              (rd_data),
        .status               (status),
        .epc                  (epc),
        .int_pending          (int_pending)
    );

    cp0_apb u_apb (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .rd_sel  (rd_sel),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

endmodule

//--- testbench/exc_tb.sv
`include "exc_config.svh"
`timescale 1ns/10ps

module exc_tb;
    import exc_pkg::*;

    localparam int TIMEOUT = 50;

    logic                  clk;
    logic                  rst;
    logic                  commit_valid;
    exc_flags_t            commit_flags;
    word_t                 commit_pc;
    word_t                 commit_vaddr;
    logic                  commit_in_delay_slot;
    logic                  commit_eret;
    logic [`INT_LINES-1:0] ext_int;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [3:0]            paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  exception_valid;
    exc_code_t             exception_code;
    logic                  redirect_valid;
    word_t                 redirect_pc;

    // outputs seen during the last commit slot
    logic      seen_exc;
    exc_code_t seen_code;
    logic      seen_redir;
    word_t     seen_pc;

    integer seed;

    exc_top UUT (.*);

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic require_done(input logic done, input string what);
        if (!done) begin
            $display("timeout while waiting for %s", what);
            stop_with_failure();
        end
    endtask

    // cause code for each flag, listed from highest to lowest rank
    function automatic exc_code_t code_for_rank(input int rank);
        case (rank)
            0:       return ADEL;
            1:       return TLBL;
            2:       return CPU;
            3:       return RI;
            4:       return OV;
            5:       return BP;
            6:       return SYS;
            7:       return TR;
            8:       return ADEL;
            9:       return ADES;
            10:      return TLBL;
            11:      return TLBS;
            default: return MOD;
        endcase
    endfunction

    // setup then access, pslverr only on a badvaddr write
    task automatic apb_transfer(input logic write, input logic [3:0] addr, input word_t wdata,
                                output word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: pready never rose for APB offset %h", addr);
            stop_with_failure();
        end else begin
            rdata = prdata;
            check_bit("apb pslverr", write && addr == `CP0_BADVADDR_OFS, pslverr);
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input word_t data);
        word_t unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [3:0] addr, output word_t data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic commit(input exc_flags_t flags, input word_t pc, input word_t vaddr,
                          input logic in_slot, input logic eret);
        @(posedge clk);
        commit_valid         <= 1'b1;
        commit_flags         <= flags;
        commit_pc            <= pc;
        commit_vaddr         <= vaddr;
        commit_in_delay_slot <= in_slot;
        commit_eret          <= eret;
        @(negedge clk);
        seen_exc   = exception_valid;
        seen_code  = exception_code;
        seen_redir = redirect_valid;
        seen_pc    = redirect_pc;
        @(posedge clk);
        commit_valid         <= 1'b0;
        commit_flags         <= '0;
        commit_in_delay_slot <= 1'b0;
        commit_eret          <= 1'b0;
    endtask

    task automatic eret_commit(input string name);
        commit('0, '0, '0, 1'b0, 1'b1);
        check_bit({name, " redirect_valid"}, 1'b1, seen_redir);
        check_bit({name, " exception_valid"}, 1'b0, seen_exc);
    endtask

    // clean commits until an interrupt is taken
    task automatic wait_for_exception(input string name);
        int tries;
        tries    = 0;
        seen_exc = 1'b0;
        while (!seen_exc && tries < TIMEOUT) begin
            commit('0, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b0);
            tries++;
        end
        require_done(seen_exc, {name, " exception"});
    endtask

    task automatic reset_values();
        word_t rd;
        @(negedge clk);
        check_bit("reset pready", 1'b0, pready);
        check_bit("reset pslverr", 1'b0, pslverr);
        check_bit("reset exception_valid", 1'b0, exception_valid);
        check_bit("reset redirect_valid", 1'b0, redirect_valid);
        apb_read(`CP0_STATUS_OFS, rd);
        check_word("reset status", 32'h0000_0004, rd);
        apb_read(`CP0_CAUSE_OFS, rd);
        check_word("reset cause", '0, rd);
        apb_read(`CP0_EPC_OFS, rd);
        check_word("reset epc", '0, rd);
        apb_read(`CP0_BADVADDR_OFS, rd);
        check_word("reset badvaddr", '0, rd);
        // read only register
        apb_write(`CP0_BADVADDR_OFS, 32'h1234_5678);
        apb_read(`CP0_BADVADDR_OFS, rd);
        check_word("badvaddr after write", '0, rd);
    endtask

    task automatic fault_priority();
        logic [12:0] bits;
        int          a;
        int          b;
        int          top;
        word_t       rd;
        cp0_cause_t  cause;
        // clear erl, exl and ie
        apb_write(`CP0_STATUS_OFS, 32'h0);
        for (int round = 0; round < 12; round++) begin
            a    = $unsigned($random(seed)) % 13;
            b    = $unsigned($random(seed)) % 13;
            top  = (a < b) ? a : b;
            bits = '0;
            // rank 0 is instr_adel, the top bit of the flag word
            bits[12 - a] = 1'b1;
            bits[12 - b] = 1'b1;
            commit(exc_flags_t'(bits), word_t'($random(seed)), word_t'($random(seed)),
                   1'b0, 1'b0);
            check_bit("priority exception_valid", 1'b1, seen_exc);
            check_code("priority exception_code", code_for_rank(top), seen_code);
            check_bit("priority redirect_valid", 1'b1, seen_redir);
            check_word("priority redirect_pc", `EXC_ENTRY, seen_pc);
            apb_read(`CP0_CAUSE_OFS, rd);
            cause = cp0_cause_t'(rd);
            check_code("priority cause exc_code", code_for_rank(top), cause.exc_code);
            eret_commit("priority eret");
        end
    endtask

    task automatic epc_and_badvaddr();
        exc_flags_t flags;
        word_t      pc;
        word_t      vaddr;
        word_t      rd;
        cp0_cause_t cause;
        pc    = word_t'($random(seed)) & 32'hffff_fffc;
        vaddr = word_t'($random(seed));
        flags = '0;
        flags.load_adel = 1'b1;
        commit(flags, pc, vaddr, 1'b1, 1'b0);
        check_code("delay slot load code", ADEL, seen_code);
        apb_read(`CP0_EPC_OFS, rd);
        check_word("delay slot epc", pc - 32'd4, rd);
        apb_read(`CP0_CAUSE_OFS, rd);
        cause = cp0_cause_t'(rd);
        check_bit("delay slot bd", 1'b1, cause.bd);
        apb_read(`CP0_BADVADDR_OFS, rd);
        check_word("load badvaddr", vaddr, rd);
        // nested fault, exl already set
        flags = '0;
        flags.ov = 1'b1;
        commit(flags, pc + 32'h100, vaddr, 1'b0, 1'b0);
        check_code("nested fault code", OV, seen_code);
        apb_read(`CP0_EPC_OFS, rd);
        check_word("nested fault epc", pc - 32'd4, rd);
        apb_read(`CP0_CAUSE_OFS, rd);
        cause = cp0_cause_t'(rd);
        check_bit("nested fault bd", 1'b1, cause.bd);
        eret_commit("delay slot eret");
    endtask

    task automatic interrupt_masking();
        exc_flags_t ov_only;
        word_t      rd;
        cp0_cause_t cause;
        int         waited;
        ov_only    = '0;
        ov_only.ov = 1'b1;
        // ie set, im clear
        apb_write(`CP0_STATUS_OFS, 32'h0000_0001);
        @(posedge clk);
        ext_int <= 6'b00_1000;
        // synchronizer plus cause register
        repeat (4) @(posedge clk);
        commit('0, word_t'($random(seed)), '0, 1'b0, 1'b0);
        check_bit("masked line exception_valid", 1'b0, seen_exc);
        apb_read(`CP0_CAUSE_OFS, rd);
        cause = cp0_cause_t'(rd);
        check_bit("line 3 in cause ip", 1'b1, cause.ip[5]);
        apb_write(`CP0_STATUS_OFS, 32'h0000_2001);
        wait_for_exception("line 3");
        check_code("line 3 code", INT, seen_code);
        eret_commit("line 3 eret");
        commit(ov_only, word_t'($random(seed)), '0, 1'b0, 1'b0);
        check_bit("line 3 over ov exception_valid", 1'b1, seen_exc);
        check_code("line 3 over ov code", INT, seen_code);
        // exl holds off interrupts while the line drops
        @(posedge clk);
        ext_int <= '0;
        waited = 0;
        apb_read(`CP0_CAUSE_OFS, rd);
        cause = cp0_cause_t'(rd);
        while (cause.ip[5] && waited < TIMEOUT) begin
            apb_read(`CP0_CAUSE_OFS, rd);
            cause = cp0_cause_t'(rd);
            waited++;
        end
        require_done(!cause.ip[5], "line 3 to clear in cause");
        // software interrupt 0
        apb_write(`CP0_CAUSE_OFS, 32'h0000_0100);
        apb_write(`CP0_STATUS_OFS, 32'h0000_0101);
        wait_for_exception("software interrupt");
        check_code("software interrupt code", INT, seen_code);
        eret_commit("software interrupt eret");
        commit(ov_only, word_t'($random(seed)), '0, 1'b0, 1'b0);
        check_bit("software over ov exception_valid", 1'b1, seen_exc);
        check_code("software over ov code", INT, seen_code);
        apb_write(`CP0_CAUSE_OFS, 32'h0);
        apb_write(`CP0_STATUS_OFS, 32'h0);
    endtask

    task automatic eret_return();
        exc_flags_t  flags;
        word_t       pc;
        word_t       rd;
        cp0_status_u st;
        pc    = word_t'($random(seed)) & 32'hffff_fffc;
        flags = '0;
        flags.bp = 1'b1;
        commit(flags, pc, '0, 1'b0, 1'b0);
        check_code("breakpoint code", BP, seen_code);
        commit('0, pc + 32'd4, '0, 1'b0, 1'b1);
        check_bit("eret redirect_valid", 1'b1, seen_redir);
        check_bit("eret exception_valid", 1'b0, seen_exc);
        check_word("eret redirect_pc", pc, seen_pc);
        apb_read(`CP0_STATUS_OFS, rd);
        st.raw = rd;
        check_bit("status exl after eret", 1'b0, st.fld.exl);
        // fault wins over eret in one slot
        flags = '0;
        flags.sys = 1'b1;
        commit(flags, pc + 32'd8, '0, 1'b0, 1'b1);
        check_bit("faulting eret exception_valid", 1'b1, seen_exc);
        check_code("faulting eret code", SYS, seen_code);
        check_word("faulting eret redirect_pc", `EXC_ENTRY, seen_pc);
        apb_read(`CP0_STATUS_OFS, rd);
        st.raw = rd;
        check_bit("status exl after faulting eret", 1'b1, st.fld.exl);
        eret_commit("final eret");
    endtask

    initial begin
        seed                 = 78;
        clk                  = 1'b0;
        rst                  = 1'b1;
        commit_valid         = 1'b0;
        commit_flags         = '0;
        commit_pc            = '0;
        commit_vaddr         = '0;
        commit_in_delay_slot = 1'b0;
        commit_eret          = 1'b0;
        ext_int              = '0;
        psel                 = 1'b0;
        penable              = 1'b0;
        pwrite               = 1'b0;
        paddr                = '0;
        pwdata               = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        fault_priority();
        epc_and_badvaddr();
        interrupt_masking();
        eret_return();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/exc_pkg.sv
logic/exc_priority.sv
logic/cp0_regs.sv
logic/cp0_apb.sv
logic/exc_top.sv
testbench/exc_tb.sv
